/* list.f */
logic/matrix_pkg.sv
logic/command_decoder.sv
logic/pixel_writer.sv
logic/panel_blanker.sv
logic/ram_write_mux.sv
logic/display_settings.sv
logic/matrix_control.sv
bench/tb_matrix_control.sv

/* bench/tb_matrix_control.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_matrix_control;

    localparam int wait_limit = 50;
    localparam int blank_limit = matrix_pkg::mem_depth + 50;

    logic clk_in;
    logic reset;
    logic [7:0] data_rx;
    logic data_ready_n;
    wire logic ready_for_data;
    wire logic busy;
    wire logic [matrix_pkg::addr_bits-1:0] ram_address;
    wire logic [7:0] ram_data_out;
    wire logic ram_write_enable;
    wire logic [2:0] rgb_enable;
    wire matrix_pkg::brightness_t brightness_enable;

    // frame memory model and write log
    logic [7:0] model_mem [0:matrix_pkg::mem_depth-1];
    int unsigned hit_count [0:matrix_pkg::mem_depth-1];
    logic [matrix_pkg::addr_bits-1:0] addr_log [$];
    logic [7:0] data_log [$];
    int write_count;

    int mismatch_count;
    int timeout_count;
    int other_count;
    int held_cycles;
    int writes_at_accept;
    integer seed;

    logic [2:0] exp_rgb;
    logic [5:0] exp_bright;

    matrix_control DUT (
        .clk_in(clk_in),
        .reset(reset),
        .data_rx(data_rx),
        .data_ready_n(data_ready_n),
        .ready_for_data(ready_for_data),
        .busy(busy),
        .ram_address(ram_address),
        .ram_data_out(ram_data_out),
        .ram_write_enable(ram_write_enable),
        .rgb_enable(rgb_enable),
        .brightness_enable(brightness_enable)
    );

    initial begin
        clk_in = 1'b0;
        forever #50 clk_in = ~clk_in;
    end

    // expected {rgb, brightness} after one single-byte command
    function automatic logic [8:0] model_settings(input logic [8:0] current,
                                                  input logic [7:0] cmd);
        logic [2:0] rgb;
        logic [5:0] bright;
        int idx;
        begin
            rgb = current[8:6];
            bright = current[5:0];
            idx = 6 - (cmd - "0");
            case (cmd)
                "R": rgb[0] = 1'b1;
                "r": rgb[0] = 1'b0;
                "G": rgb[1] = 1'b1;
                "g": rgb[1] = 1'b0;
                "B": rgb[2] = 1'b1;
                "b": rgb[2] = 1'b0;
                "0": bright = 6'b000000;
                "9": bright = 6'b111111;
                // digit 1 is the top bit
                "1", "2", "3", "4", "5", "6": bright[idx] = ~bright[idx];
                default: ;
            endcase
            return {rgb, bright};
        end
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            mismatch_count++;
            $display("Mismatch at %0t: %s got %0h expected %0h", $time, name, actual, expected);
        end
    endtask

    task automatic send_byte(input logic [7:0] value);
        int waited;
        begin
            @(posedge clk_in);
            data_rx <= value;
            data_ready_n <= 1'b0;
            waited = 0;
            @(negedge clk_in);
            while (!ready_for_data && waited < wait_limit) begin
                @(negedge clk_in);
                waited++;
            end
            if (!ready_for_data) begin
                timeout_count++;
                $display("Timeout at %0t: ready_for_data stayed low for byte %h", $time, value);
            end
            held_cycles = waited;
            writes_at_accept = write_count;
            @(posedge clk_in);
            data_ready_n <= 1'b1;
        end
    endtask

    // settings take two cycles after acceptance, then wait for idle
    task automatic settle_and_check;
        int waited;
        begin
            repeat (2) @(posedge clk_in);
            waited = 0;
            @(negedge clk_in);
            while (busy && waited < wait_limit) begin
                @(negedge clk_in);
                waited++;
            end
            if (busy) begin
                timeout_count++;
                $display("Timeout at %0t: decoder did not return to idle", $time);
            end
            check_value("rgb_enable", rgb_enable, exp_rgb);
            check_value("brightness_enable", brightness_enable, exp_bright);
        end
    endtask

    task automatic send_command(input logic [7:0] cmd);
        send_byte(cmd);
        {exp_rgb, exp_bright} = model_settings({exp_rgb, exp_bright}, cmd);
        settle_and_check();
    endtask

    // records every frame memory write mid-cycle
    always @(negedge clk_in) begin
        if (!reset && ram_write_enable) begin
            if (!busy) begin
                other_count++;
                $display("Error at %0t: frame memory written while the decoder was idle", $time);
            end
            model_mem[ram_address] = ram_data_out;
            hit_count[ram_address] = hit_count[ram_address] + 1;
            addr_log.push_back(ram_address);
            data_log.push_back(ram_data_out);
            write_count++;
        end
    end

    initial begin
        logic [7:0] value;
        logic [4:0] row;
        logic [5:0] col;
        logic [7:0] first;
        logic [7:0] second;
        logic [matrix_pkg::addr_bits-1:0] pix_addr;
        int waited;
        mismatch_count = 0;
        timeout_count = 0;
        other_count = 0;
        write_count = 0;
        seed = 32'h1fb0;
        reset = 1'b1;
        data_rx = 8'h00;
        data_ready_n = 1'b1;
        exp_rgb = 3'b111;
        exp_bright = 6'b111111;
        for (int a = 0; a < matrix_pkg::mem_depth; a++) begin
            model_mem[a] = 8'ha5 ^ a[7:0] ^ {a[11:8], 4'h0};
            hit_count[a] = 0;
        end
        repeat (5) @(posedge clk_in);
        reset <= 1'b0;

        // state after reset
        @(negedge clk_in);
        check_value("rgb_enable", rgb_enable, 3'b111);
        check_value("brightness_enable", brightness_enable, 6'b111111);
        check_value("ready_for_data", ready_for_data, 1'b1);
        check_value("busy", busy, 1'b0);
        check_value("ram_write_enable", ram_write_enable, 1'b0);

        // colour planes
        send_command("r");
        send_command("g");
        send_command("b");
        send_command("R");
        send_command("b");
        send_command("G");
        send_command("B");
        send_command("g");

        // brightness digits mixed with bytes the decoder ignores
        for (int n = 0; n < 30; n++) begin
            value = $random(seed);
            if (value[0]) begin
                value = (value[3:1] == 3'd7) ? "9" : ("0" + value[3:1]);
            end else if (value == "T" || value == "P" || value == "Z") begin
                value = 8'h7e;
            end
            send_command(value);
        end

        // brightness load
        for (int n = 0; n < 3; n++) begin
            value = $random(seed);
            send_byte("T");
            send_byte(value);
            exp_bright = value[5:0];
            settle_and_check();
        end

        // pixel write
        row = $random(seed);
        col = $random(seed);
        first = $random(seed);
        second = $random(seed);
        pix_addr = {row, col, 1'b0};
        write_count = 0;
        addr_log.delete();
        data_log.delete();
        send_byte("P");
        send_byte({3'b000, row});
        send_byte({2'b00, col});
        send_byte(first);
        send_byte(second);
        send_byte(8'h20);
        if (held_cycles == 0) begin
            other_count++;
            $display("Error at %0t: next host byte was not held off during the pixel write",
                     $time);
        end
        check_value("writes before next byte", writes_at_accept, 2);
        settle_and_check();
        check_value("pixel write count", write_count, 2);
        if (addr_log.size() == 2) begin
            check_value("first byte address", addr_log[0], pix_addr);
            check_value("first byte data", data_log[0], first);
            check_value("second byte address", addr_log[1], pix_addr | 1);
            check_value("second byte data", data_log[1], second);
        end

        // blank the frame
        write_count = 0;
        for (int a = 0; a < matrix_pkg::mem_depth; a++) hit_count[a] = 0;
        send_byte("Z");
        waited = 0;
        @(negedge clk_in);
        while (!busy && waited < wait_limit) begin
            @(negedge clk_in);
            waited++;
        end
        if (!busy) begin
            timeout_count++;
            $display("Timeout at %0t: busy never rose after the blank command", $time);
        end
        waited = 0;
        while (busy && waited < blank_limit) begin
            @(negedge clk_in);
            waited++;
        end
        if (busy) begin
            timeout_count++;
            $display("Timeout at %0t: busy stayed high during the blank", $time);
        end
        check_value("writes when busy fell", write_count, matrix_pkg::mem_depth);
        repeat (3) @(negedge clk_in);
        check_value("writes after blank", write_count, matrix_pkg::mem_depth);
        check_value("busy", busy, 1'b0);
        check_value("earlier pixel byte", model_mem[pix_addr], 8'h00);
        check_value("earlier pixel byte", model_mem[pix_addr | 1], 8'h00);
        for (int a = 0; a < matrix_pkg::mem_depth; a++) begin
            check_value($sformatf("hit_count[%0d]", a), hit_count[a], 1);
            check_value($sformatf("model_mem[%0d]", a), model_mem[a], 8'h00);
        end

        $display("errors: %0d mismatches, %0d timeouts, %0d other",
                 mismatch_count, timeout_count, other_count);
        if (mismatch_count + timeout_count + other_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* logic/matrix_control.sv */
`timescale 1ns/1ps
`default_nettype none

module matrix_control (
    input  wire logic clk_in,
    input  wire logic reset,
    input  wire logic [7:0] data_rx,
    input  wire logic data_ready_n,
    output logic ready_for_data,
    output logic busy,
    output logic [matrix_pkg::addr_bits-1:0] ram_address,
    output logic [7:0] ram_data_out,
    output logic ram_write_enable,
    output logic [2:0] rgb_enable,
    output matrix_pkg::brightness_t brightness_enable
);

    logic [2:0] rgb_set;
    logic [2:0] rgb_clear;
    matrix_pkg::brightness_t bright_toggle;
    logic bright_clear;
    logic bright_set;
    logic bright_load;
    matrix_pkg::brightness_t bright_value;

    logic pixel_start;
    logic pixel_done;
    logic [matrix_pkg::row_bits-1:0] pixel_row;
    logic [matrix_pkg::col_bits-1:0] pixel_col;
    logic [7:0] pixel_first;
    logic [7:0] pixel_second;

    logic pix_wr_enable;
    logic [matrix_pkg::row_bits-1:0] pix_wr_row;
    logic [matrix_pkg::col_bits-1:0] pix_wr_col;
    logic [matrix_pkg::byte_sel_bits-1:0] pix_wr_byte_sel;
    logic [7:0] pix_wr_data;

    logic blank_start;
    logic blank_done;
    logic blank_wr_enable;
    matrix_pkg::ram_addr_t blank_wr_addr;

    command_decoder u_decoder (
        .clk_in(clk_in),
        .reset(reset),
        .data_rx(data_rx),
        .data_ready_n(data_ready_n),
        .pixel_done(pixel_done),
        .blank_done(blank_done),
        .ready_for_data(ready_for_data),
        .busy(busy),
        .rgb_set(rgb_set),
        .rgb_clear(rgb_clear),
        .bright_toggle(bright_toggle),
        .bright_clear(bright_clear),
        .bright_set(bright_set),
        .bright_load(bright_load),
        .bright_value(bright_value),
        .pixel_start(pixel_start),
        .pixel_row(pixel_row),
        .pixel_col(pixel_col),
        .pixel_first(pixel_first),
        .pixel_second(pixel_second),
        .blank_start(blank_start)
    );

    pixel_writer u_pixel (
        .clk_in(clk_in),
        .reset(reset),
        .pixel_start(pixel_start),
        .pixel_row(pixel_row),
        .pixel_col(pixel_col),
        .pixel_first(pixel_first),
        .pixel_second(pixel_second),
        .wr_enable(pix_wr_enable),
        .wr_row(pix_wr_row),
        .wr_col(pix_wr_col),
        .wr_byte_sel(pix_wr_byte_sel),
        .wr_data(pix_wr_data),
        .pixel_done(pixel_done)
    );

    panel_blanker u_blanker (
        .clk_in(clk_in),
        .reset(reset),
        .blank_start(blank_start),
        .wr_enable(blank_wr_enable),
        .wr_addr(blank_wr_addr),
        .blank_done(blank_done)
    );

    ram_write_mux u_mux (
        .pixel_wr_enable(pix_wr_enable),
        .pixel_row(pix_wr_row),
        .pixel_col(pix_wr_col),
        .pixel_byte_sel(pix_wr_byte_sel),
        .pixel_data(pix_wr_data),
        .blank_wr_enable(blank_wr_enable),
        .blank_addr(blank_wr_addr),
        .ram_address(ram_address),
        .ram_data_out(ram_data_out),
        .ram_write_enable(ram_write_enable)
    );

    display_settings u_settings (
        .clk_in(clk_in),
        .reset(reset),
        .rgb_set(rgb_set),
        .rgb_clear(rgb_clear),
        .bright_toggle(bright_toggle),
        .bright_clear(bright_clear),
        .bright_set(bright_set),
        .bright_load(bright_load),
        .bright_value(bright_value),
        .rgb_enable(rgb_enable),
        .brightness_enable(brightness_enable)
    );

endmodule

`default_nettype wire

/* logic/display_settings.sv */
`timescale 1ns/1ps
`default_nettype none

module display_settings (
    input  wire logic clk_in,
    input  wire logic reset,
    input  wire logic [2:0] rgb_set,
    input  wire logic [2:0] rgb_clear,
    input  wire matrix_pkg::brightness_t bright_toggle,
    input  wire logic bright_clear,
    input  wire logic bright_set,
    input  wire logic bright_load,
    input  wire matrix_pkg::brightness_t bright_value,
    output logic [2:0] rgb_enable,
    output matrix_pkg::brightness_t brightness_enable
);

    matrix_pkg::brightness_t bright_next;

    always_comb begin
        // load wins, then clear or set, then toggle
        if (bright_load) begin
            bright_next = bright_value;
        end else if (bright_clear) begin
            bright_next = '0;
        end else if (bright_set) begin
            bright_next = '1;
        end else begin
            bright_next = brightness_enable ^ bright_toggle;
        end
    end

    always_ff @(posedge clk_in or posedge reset) begin
        if (reset) begin
            rgb_enable <= 3'b111;
            brightness_enable <= '1;
        end else begin
            rgb_enable <= (rgb_enable | rgb_set) & ~rgb_clear;
            brightness_enable <= bright_next;
        end
    end

endmodule

`default_nettype wire

/* logic/ram_write_mux.sv */
`timescale 1ns/1ps
`default_nettype none

module ram_write_mux (
    input  wire logic pixel_wr_enable,
    input  wire logic [matrix_pkg::row_bits-1:0] pixel_row,
    input  wire logic [matrix_pkg::col_bits-1:0] pixel_col,
    input  wire logic [matrix_pkg::byte_sel_bits-1:0] pixel_byte_sel,
    input  wire logic [7:0] pixel_data,
    input  wire logic blank_wr_enable,
    input  wire matrix_pkg::ram_addr_t blank_addr,
    output logic [matrix_pkg::addr_bits-1:0] ram_address,
    output logic [7:0] ram_data_out,
    output logic ram_write_enable
);

    logic [matrix_pkg::addr_bits-1:0] pixel_address;
    logic [matrix_pkg::addr_bits-1:0] blank_address;

    // byte select is inverted, so the first colour byte lands at the even address
    assign pixel_address = {pixel_row, pixel_col, ~pixel_byte_sel};
    assign blank_address = {blank_addr.row, blank_addr.col, ~blank_addr.byte_sel};

    always_comb begin
        if (pixel_wr_enable) begin
            ram_address = pixel_address;
            ram_data_out = pixel_data;
        end else begin
            ram_address = blank_address;
            ram_data_out = 8'h00;
        end
    end

    assign ram_write_enable = pixel_wr_enable | blank_wr_enable;

    // decoder must never run both writers at once
    always_comb begin
        assert final (!(pixel_wr_enable && blank_wr_enable))
            else $error("ram_write_mux: pixel and blank writers active together");
    end

endmodule

`default_nettype wire

/* logic/panel_blanker.sv */
`timescale 1ns/1ps
`default_nettype none

module panel_blanker (
    input  wire logic clk_in,
    input  wire logic reset,
    input  wire logic blank_start,
    output logic wr_enable,
    output matrix_pkg::ram_addr_t wr_addr,
    output logic blank_done
);

    logic [matrix_pkg::addr_bits-1:0] count;
    logic active;
    logic last_addr;

    assign last_addr = (count == matrix_pkg::addr_bits'(matrix_pkg::mem_depth - 1));

    always_ff @(posedge clk_in or posedge reset) begin
        if (reset) begin
            active <= 1'b0;
            count <= '0;
        end else if (blank_start) begin
            active <= 1'b1;
            count <= '0;
        end else if (active) begin
            // counter wraps back to zero after the last address
            if (last_addr) active <= 1'b0;
            count <= count + 1'b1;
        end
    end

    assign wr_enable = active;
    assign wr_addr = count;
    assign blank_done = active & last_addr;

endmodule

`default_nettype wire

/* logic/pixel_writer.sv */
`timescale 1ns/1ps
`default_nettype none

module pixel_writer (
    input  wire logic clk_in,
    input  wire logic reset,
    input  wire logic pixel_start,
    input  wire logic [matrix_pkg::row_bits-1:0] pixel_row,
    input  wire logic [matrix_pkg::col_bits-1:0] pixel_col,
    input  wire logic [7:0] pixel_first,
    input  wire logic [7:0] pixel_second,
    output logic wr_enable,
    output logic [matrix_pkg::row_bits-1:0] wr_row,
    output logic [matrix_pkg::col_bits-1:0] wr_col,
    output logic [matrix_pkg::byte_sel_bits-1:0] wr_byte_sel,
    output logic [7:0] wr_data,
    output logic pixel_done
);

    logic write_first;
    logic write_second;

    // two-step sequencer
    always_ff @(posedge clk_in or posedge reset) begin
        if (reset) begin
            write_first <= 1'b0;
            write_second <= 1'b0;
        end else begin
            write_first <= pixel_start;
            write_second <= write_first;
        end
    end

    assign wr_enable = write_first | write_second;
    assign wr_row = pixel_row;
    assign wr_col = pixel_col;

    // first colour byte is the high byte of the pixel
    assign wr_byte_sel = write_first ? 1'b1 : 1'b0;
    assign wr_data = write_first ? pixel_first : pixel_second;
    assign pixel_done = write_second;

    assert property (@(posedge clk_in) disable iff (reset)
                     pixel_start |-> !(write_first || write_second))
        else $error("pixel_writer: pixel_start during a write in progress");

endmodule

`default_nettype wire

/* logic/command_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module command_decoder (
    input  wire logic clk_in,
    input  wire logic reset,
    input  wire logic [7:0] data_rx,
    input  wire logic data_ready_n,
    input  wire logic pixel_done,
    input  wire logic blank_done,
    output logic ready_for_data,
    output logic busy,
    output logic [2:0] rgb_set,
    output logic [2:0] rgb_clear,
    output matrix_pkg::brightness_t bright_toggle,
    output logic bright_clear,
    output logic bright_set,
    output logic bright_load,
    output matrix_pkg::brightness_t bright_value,
    output logic pixel_start,
    output logic [matrix_pkg::row_bits-1:0] pixel_row,
    output logic [matrix_pkg::col_bits-1:0] pixel_col,
    output logic [7:0] pixel_first,
    output logic [7:0] pixel_second,
    output logic blank_start
);

    matrix_pkg::cmd_state_t state;
    logic [7:0] data_latch;
    logic byte_valid;
    logic accept;
    logic entering_write;

    assign accept = ~data_ready_n & ready_for_data;

    // hold the host off as soon as the pending byte starts a write
    assign entering_write = byte_valid &&
        ((state == matrix_pkg::st_pixel_second) ||
         (state == matrix_pkg::st_idle && data_latch == matrix_pkg::cmd_blank));

    assign ready_for_data = !(state == matrix_pkg::st_pixel_write ||
                              state == matrix_pkg::st_blank || entering_write);
    assign busy = (state != matrix_pkg::st_idle);

    always_ff @(posedge clk_in) begin
        if (accept) begin
            data_latch <= data_rx;
        end
    end

    always_ff @(posedge clk_in or posedge reset) begin
        if (reset) begin
            state <= matrix_pkg::st_idle;
            byte_valid <= 1'b0;
            rgb_set <= '0;
            rgb_clear <= '0;
            bright_toggle <= '0;
            bright_clear <= 1'b0;
            bright_set <= 1'b0;
            bright_load <= 1'b0;
            pixel_start <= 1'b0;
            blank_start <= 1'b0;
        end else begin
            byte_valid <= accept;
            rgb_set <= '0;
            rgb_clear <= '0;
            bright_toggle <= '0;
            bright_clear <= 1'b0;
            bright_set <= 1'b0;
            bright_load <= 1'b0;
            pixel_start <= 1'b0;
            blank_start <= 1'b0;
            case (state)
                matrix_pkg::st_idle: begin
                    if (byte_valid) begin
                        case (data_latch)
                            matrix_pkg::cmd_red_on: rgb_set <= 3'b001;
                            matrix_pkg::cmd_red_off: rgb_clear <= 3'b001;
                            matrix_pkg::cmd_green_on: rgb_set <= 3'b010;
                            matrix_pkg::cmd_green_off: rgb_clear <= 3'b010;
                            matrix_pkg::cmd_blue_on: rgb_set <= 3'b100;
                            matrix_pkg::cmd_blue_off: rgb_clear <= 3'b100;
                            // digit 1 is the top brightness bit
                            matrix_pkg::cmd_toggle_1: bright_toggle <= 6'b100000;
                            matrix_pkg::cmd_toggle_2: bright_toggle <= 6'b010000;
                            matrix_pkg::cmd_toggle_3: bright_toggle <= 6'b001000;
                            matrix_pkg::cmd_toggle_4: bright_toggle <= 6'b000100;
                            matrix_pkg::cmd_toggle_5: bright_toggle <= 6'b000010;
                            matrix_pkg::cmd_toggle_6: bright_toggle <= 6'b000001;
                            matrix_pkg::cmd_bright_clear: bright_clear <= 1'b1;
                            matrix_pkg::cmd_bright_set: bright_set <= 1'b1;
                            matrix_pkg::cmd_bright_load: state <= matrix_pkg::st_bright_arg;
                            matrix_pkg::cmd_pixel: state <= matrix_pkg::st_pixel_row;
                            matrix_pkg::cmd_blank: begin
                                state <= matrix_pkg::st_blank;
                                blank_start <= 1'b1;
                            end
                            default: state <= matrix_pkg::st_idle;
                        endcase
                    end
                end
                matrix_pkg::st_bright_arg: begin
                    if (byte_valid) begin
                        bright_load <= 1'b1;
                        state <= matrix_pkg::st_idle;
                    end
                end
                matrix_pkg::st_pixel_row: begin
                    if (byte_valid) state <= matrix_pkg::st_pixel_col;
                end
                matrix_pkg::st_pixel_col: begin
                    if (byte_valid) state <= matrix_pkg::st_pixel_first;
                end
                matrix_pkg::st_pixel_first: begin
                    if (byte_valid) state <= matrix_pkg::st_pixel_second;
                end
                matrix_pkg::st_pixel_second: begin
                    if (byte_valid) begin
                        pixel_start <= 1'b1;
                        state <= matrix_pkg::st_pixel_write;
                    end
                end
                matrix_pkg::st_pixel_write: begin
                    if (pixel_done) state <= matrix_pkg::st_idle;
                end
                matrix_pkg::st_blank: begin
                    if (blank_done) state <= matrix_pkg::st_idle;
                end
                default: state <= matrix_pkg::st_idle;
            endcase
        end
    end

    // argument bytes
    always_ff @(posedge clk_in) begin
        if (byte_valid) begin
            case (state)
                matrix_pkg::st_bright_arg: bright_value <= data_latch[5:0];
                matrix_pkg::st_pixel_row: pixel_row <= data_latch[4:0];
                matrix_pkg::st_pixel_col: pixel_col <= data_latch[5:0];
                matrix_pkg::st_pixel_first: pixel_first <= data_latch;
                matrix_pkg::st_pixel_second: pixel_second <= data_latch;
                default: ;
            endcase
        end
    end

    // a byte never lands in a state that would drop it
    assert property (@(posedge clk_in) disable iff (reset)
                     byte_valid |-> !(state == matrix_pkg::st_pixel_write ||
                                      state == matrix_pkg::st_blank))
        else $error("command_decoder: byte accepted while a write was running");

endmodule

`default_nettype wire

/* logic/matrix_pkg.sv */
`default_nettype none

package matrix_pkg;

    // 64x32 panel, two bytes per pixel
    localparam int row_bits = 5;
    localparam int col_bits = 6;
    localparam int byte_sel_bits = 1;
    localparam int addr_bits = row_bits + col_bits + byte_sel_bits;
    localparam int mem_depth = 1 << addr_bits;

    localparam int brightness_levels = 6;

    typedef struct packed {
        logic [row_bits-1:0] row;
        logic [col_bits-1:0] col;
        logic [byte_sel_bits-1:0] byte_sel;
    } ram_addr_t;

    typedef logic [brightness_levels-1:0] brightness_t;

    typedef enum logic [2:0] {
        st_idle,
        st_bright_arg,
        st_pixel_row,
        st_pixel_col,
        st_pixel_first,
        st_pixel_second,
        st_pixel_write,
        st_blank
    } cmd_state_t;

    // command bytes, ascii
    localparam logic [7:0] cmd_red_on = "R";
    localparam logic [7:0] cmd_red_off = "r";
    localparam logic [7:0] cmd_green_on = "G";
    localparam logic [7:0] cmd_green_off = "g";
    localparam logic [7:0] cmd_blue_on = "B";
    localparam logic [7:0] cmd_blue_off = "b";
    localparam logic [7:0] cmd_bright_clear = "0";
    localparam logic [7:0] cmd_toggle_1 = "1";
    localparam logic [7:0] cmd_toggle_2 = "2";
    localparam logic [7:0] cmd_toggle_3 = "3";
    localparam logic [7:0] cmd_toggle_4 = "4";
    localparam logic [7:0] cmd_toggle_5 = "5";
    localparam logic [7:0] cmd_toggle_6 = "6";
    localparam logic [7:0] cmd_bright_set = "9";
    localparam logic [7:0] cmd_bright_load = "T";
    localparam logic [7:0] cmd_pixel = "P";
    localparam logic [7:0] cmd_blank = "Z";

endpackage

`default_nettype wire
